// File: Makefile
# Verilator build and run for the instruction fetch testbench
# variables below can be overridden on the command line, e.g.
#   make test SEED_ARGS=-GSEED=12345

VERILATOR ?= verilator
TOP       ?= fetch_tb
SEED_ARGS ?=
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and look for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP SEED_ARGS OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) $(SEED_ARGS) -f compile.f --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "make test: passed"; \
	else \
		echo "make test: failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+design
design/fetch_pkg.sv
design/prefetch.sv
design/insn_queue.sv
design/fetch_ip_tracker.sv
design/instruction_fetch.sv
dv/tb_clock.sv
dv/fetch_tb.sv

// File: design/fetch_ip_tracker.sv
// Head byte IP tracker
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_ip_tracker (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_new_ip,
    input  fetch_pkg::offset_t new_ip,
    input  logic               rd_en,
    output fetch_pkg::offset_t fetch_ip
);

    // follows the offset of the byte at the head of the queue
    // a branch flushes the queue, so the head then belongs to the new target
    // and the load has to win over a pop in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_ip <= `FETCH_RESET_IP;
        end else if (load_new_ip) begin
            fetch_ip <= new_ip;
        end else if (rd_en) begin
            // one byte consumed, wrapping at the segment limit
            fetch_ip <= fetch_ip + 16'd1;
        end
    end

endmodule

// File: design/fetch_pkg.sv
// Instruction fetch types
package fetch_pkg;

    // a single instruction byte as it sits in the queue
    typedef logic [7:0] byte_t;

    // a memory data word, the byte at the odd address is in bits 15:8
    typedef logic [15:0] word_t;

    // segment selectors and IP offsets share this width
    // arithmetic on an offset wraps inside the 64 KB segment
    typedef logic [15:0] offset_t;

    // word address on the memory port
    // this holds physical address bits 19:1, bit 0 is implied by the byte lane
    typedef logic [18:0] waddr_t;

endpackage

// File: design/fetch_settings.svh
// Instruction fetch settings
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// number of instruction bytes the queue can hold
// the prefetcher needs room for two bytes before it starts a word fetch,
// so this must be at least 2
`define FETCH_QUEUE_DEPTH 6

// code segment used after reset, the top of the 1 MB space on an 8086
`define FETCH_RESET_CS 16'hffff

// offset used after reset, the first fetch comes from CS:0000
`define FETCH_RESET_IP 16'h0000

`endif

// File: design/insn_queue.sv
// Instruction byte queue
`timescale 1ns/100ps
`include "fetch_settings.svh"

module insn_queue #(
    parameter int unsigned DEPTH = `FETCH_QUEUE_DEPTH,
    parameter int unsigned LEVEL_W = $clog2(DEPTH + 1)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic                  flush,
    input  fetch_pkg::byte_t      wr_data,
    input  logic                  rd_en,
    output fetch_pkg::byte_t      rd_data,
    output logic [LEVEL_W-1:0]    level,
    output logic                  empty
);

    localparam int unsigned PTR_W = $clog2(DEPTH);

    fetch_pkg::byte_t   mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [LEVEL_W-1:0] count;
    logic [LEVEL_W-1:0] count_next;
    logic               do_write;
    logic               do_read;

    // the depth need not be a power of two, so pointers wrap explicitly
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // a flush discards any write or read in the same cycle
    assign do_write = wr_en && !flush && (count != LEVEL_W'(DEPTH));
    assign do_read  = rd_en && !flush && (count != '0);

    always_comb begin
        count_next = count;
        if (do_write && !do_read) begin
            count_next = count + 1'b1;
        end else if (do_read && !do_write) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
        end else begin
            if (do_write) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_next;
            // empty falls a cycle after the first byte lands, but rises
            // on the same edge that pops the last byte
            empty <= (count_next == '0) || (count == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // head byte is always on show
    assign rd_data = mem[rd_ptr];

    // the prefetcher counts bytes written but not yet visible too
    assign level = count;

endmodule

// File: design/instruction_fetch.sv
// Instruction fetch front end
`timescale 1ns/100ps
`include "fetch_settings.svh"

module instruction_fetch (
    input  logic               clk,
    input  logic               reset,
    // branch target
    input  fetch_pkg::offset_t new_cs,
    input  fetch_pkg::offset_t new_ip,
    input  logic               load_new_ip,
    // memory port
    output logic               mem_access,
    input  logic               mem_ack,
    output fetch_pkg::waddr_t  mem_address,
    input  fetch_pkg::word_t   mem_data,
    // decoder side
    input  logic               rd_en,
    output fetch_pkg::byte_t   rd_data,
    output logic               empty,
    output fetch_pkg::offset_t fetch_ip
);

    localparam int unsigned LEVEL_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic               fifo_wr_en;
    logic               fifo_flush;
    fetch_pkg::byte_t   fifo_wr_data;
    logic [LEVEL_W-1:0] fifo_level;

    prefetch #(
        .DEPTH   (`FETCH_QUEUE_DEPTH),
        .LEVEL_W (LEVEL_W)
    ) u_prefetch (
        .clk          (clk),
        .reset        (reset),
        .new_cs       (new_cs),
        .new_ip       (new_ip),
        .load_new_ip  (load_new_ip),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_flush   (fifo_flush),
        .fifo_wr_data (fifo_wr_data),
        .fifo_level   (fifo_level),
        .mem_access   (mem_access),
        .mem_ack      (mem_ack),
        .mem_address  (mem_address),
        .mem_data     (mem_data)
    );

    insn_queue #(
        .DEPTH   (`FETCH_QUEUE_DEPTH),
        .LEVEL_W (LEVEL_W)
    ) u_queue (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (fifo_wr_en),
        .flush   (fifo_flush),
        .wr_data (fifo_wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .level   (fifo_level),
        .empty   (empty)
    );

    // the tracker sees the same branch and pop strobes as the queue
    fetch_ip_tracker u_ip (
        .clk         (clk),
        .reset       (reset),
        .load_new_ip (load_new_ip),
        .new_ip      (new_ip),
        .rd_en       (rd_en),
        .fetch_ip    (fetch_ip)
    );

endmodule

// File: design/prefetch.sv
// Instruction prefetcher
`timescale 1ns/100ps
`include "fetch_settings.svh"

module prefetch #(
    parameter int unsigned DEPTH = `FETCH_QUEUE_DEPTH,
    parameter int unsigned LEVEL_W = $clog2(DEPTH + 1)
) (
    input  logic                  clk,
    input  logic                  reset,
    // branch target
    input  fetch_pkg::offset_t    new_cs,
    input  fetch_pkg::offset_t    new_ip,
    input  logic                  load_new_ip,
    // queue write side
    output logic                  fifo_wr_en,
    output logic                  fifo_flush,
    output fetch_pkg::byte_t      fifo_wr_data,
    input  logic [LEVEL_W-1:0]    fifo_level,
    // memory port
    output logic                  mem_access,
    input  logic                  mem_ack,
    output fetch_pkg::waddr_t     mem_address,
    input  fetch_pkg::word_t      mem_data
);

    // an access may only start when two bytes of room are left
    localparam logic [LEVEL_W-1:0] ROOM_LIMIT = LEVEL_W'(DEPTH - 2);

    // segment and offset of the next byte to be fetched
    fetch_pkg::offset_t cs;
    fetch_pkg::offset_t fetch_offset;
    // target of a branch that arrived while an access was in flight
    fetch_pkg::offset_t pend_cs;
    fetch_pkg::offset_t pend_ip;
    // set while the access in flight belongs to the old instruction stream
    logic               abort_cur;
    // high half of an even-aligned word, written one cycle after the ack
    fetch_pkg::byte_t   high_byte;
    logic               write_second;
    // holds fetching off until the first edge after reset
    logic               fetch_en;

    logic               ack_ok;
    logic               stale_ack;
    logic               fifo_full;
    fetch_pkg::offset_t next_offset;
    logic [19:0]        phys_addr;

    // an ack either carries bytes for the queue or is dropped after a branch
    assign ack_ok    = mem_ack && !abort_cur;
    assign stale_ack = mem_ack && abort_cur;

    // the queue is too full to take a whole word
    assign fifo_full = fifo_level > ROOM_LIMIT;

    // on a good ack the offset moves on by one, so the address already points
    // at the word that will be fetched next
    assign next_offset = ack_ok ? fetch_offset + 16'd1 : fetch_offset;

    // physical address is CS * 16 + offset, truncated to 20 bits
    assign phys_addr   = {cs, 4'b0000} + {4'b0000, next_offset};
    assign mem_address = phys_addr[19:1];

    // request stays up until the ack, and is dropped while the second byte of
    // a word goes into the queue
    assign mem_access = fetch_en && !fifo_full && !mem_ack && !write_second;

    // a branch empties the queue at once, and the stale ack empties it again
    // in case anything slipped in between
    assign fifo_flush = load_new_ip || stale_ack;

    // nothing is written in a cycle where the queue is being flushed
    assign fifo_wr_en = !load_new_ip && (ack_ok || write_second);

    // an odd offset wants the high lane straight from the bus
    assign fifo_wr_data = mem_ack ? (fetch_offset[0] ? mem_data[15:8] : mem_data[7:0])
                                  : high_byte;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // a branch during a visible request marks that access as aborted,
    // the flag clears when its ack comes back
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            abort_cur <= 1'b0;
        end else if (stale_ack) begin
            abort_cur <= 1'b0;
        end else if (mem_access && load_new_ip) begin
            abort_cur <= 1'b1;
        end
    end

    // an even offset means the high byte of the same word is needed next
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            write_second <= 1'b0;
        end else begin
            write_second <= ack_ok && !fetch_offset[0] && !load_new_ip;
        end
    end

    // keep the high lane for the second write
    always_ff @(posedge clk) begin
        if (mem_ack) begin
            high_byte <= mem_data[15:8];
        end
    end

    // pending target, only read back once a stale ack has returned
    always_ff @(posedge clk) begin
        if (load_new_ip) begin
            pend_cs <= new_cs;
            pend_ip <= new_ip;
        end
    end

    // with no access visible a branch takes effect immediately, otherwise the
    // address holds until the aborted access is finished
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cs           <= `FETCH_RESET_CS;
            fetch_offset <= `FETCH_RESET_IP;
        end else if (load_new_ip && !mem_access) begin
            cs           <= new_cs;
            fetch_offset <= new_ip;
        end else if (stale_ack) begin
            cs           <= pend_cs;
            fetch_offset <= pend_ip;
        end else if (fifo_wr_en) begin
            // wraps inside the segment
            fetch_offset <= fetch_offset + 16'd1;
        end
    end

endmodule

// File: dv/fetch_tb.sv
// Instruction fetch testbench
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_tb #(
    parameter logic [31:0] SEED = 32'h9e75f41b
);

    // length of each test phase in clock cycles
    localparam int unsigned SEQ_CYCLES     = 600;
    localparam int unsigned BP_ROUNDS      = 6;
    localparam int unsigned BP_HOLD        = 40;
    localparam int unsigned BP_RUN         = 40;
    localparam int unsigned BRANCH_CYCLES  = 1500;
    localparam int unsigned WRAP_WAIT      = 200;
    localparam int unsigned TAIL_CYCLES    = 10;
    localparam int unsigned PLANNED_CYCLES = 2 + SEQ_CYCLES + BP_ROUNDS * (BP_HOLD + BP_RUN)
                                           + BRANCH_CYCLES + WRAP_WAIT + TAIL_CYCLES + 2;

    logic                  clk;
    logic                  reset;
    fetch_pkg::offset_t    new_cs;
    fetch_pkg::offset_t    new_ip;
    logic                  load_new_ip;
    logic                  mem_access;
    logic                  mem_ack;
    fetch_pkg::waddr_t     mem_address;
    fetch_pkg::word_t      mem_data;
    logic                  rd_en;
    fetch_pkg::byte_t      rd_data;
    logic                  empty;
    fetch_pkg::offset_t    fetch_ip;

    int unsigned           errors = 0;
    int unsigned           checks = 0;
    int unsigned           pops = 0;
    int unsigned           branches = 0;
    logic [31:0]           rng_state = SEED;

    // memory model state
    // the request is counted at each falling edge
    int unsigned           req_cycles = 0;
    int unsigned           mem_latency = 1;
    fetch_pkg::waddr_t     req_addr;
    logic                  first_req = 1'b1;

    // reference model of the head byte position
    fetch_pkg::offset_t    exp_cs = `FETCH_RESET_CS;
    fetch_pkg::offset_t    exp_ip = `FETCH_RESET_IP;

    tb_clock u_clock (
        .clk (clk)
    );

    instruction_fetch u_dut (
        .clk         (clk),
        .reset       (reset),
        .new_cs      (new_cs),
        .new_ip      (new_ip),
        .load_new_ip (load_new_ip),
        .mem_access  (mem_access),
        .mem_ack     (mem_ack),
        .mem_address (mem_address),
        .mem_data    (mem_data),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .empty       (empty),
        .fetch_ip    (fetch_ip)
    );

    // 32-bit xorshift on one shared state
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // the physical address is CS times 16 plus the offset in 20 bits
    function automatic logic [19:0] phys_of(input fetch_pkg::offset_t cs,
                                            input fetch_pkg::offset_t ip);
        logic [31:0] full;
        full = 32'(cs) * 32'd16 + 32'(ip);
        return full[19:0];
    endfunction

    // content of memory at one physical byte address
    function automatic fetch_pkg::byte_t byte_at(input logic [19:0] p);
        return (p[7:0] ^ p[15:8] ^ {4'b0000, p[19:16]}) + 8'h5a;
    endfunction

    // the odd byte sits in the high half of the word
    function automatic fetch_pkg::word_t word_at(input fetch_pkg::waddr_t w);
        return {byte_at({w, 1'b1}), byte_at({w, 1'b0})};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // ack once the request has been visible for the chosen latency,
    // otherwise put noise on the data bus
    task automatic drive_memory();
        mem_ack  = 1'b0;
        mem_data = fetch_pkg::word_t'(next_rand());
        if (req_cycles != 0 && req_cycles >= mem_latency) begin
            mem_ack     = 1'b1;
            mem_data    = word_at(req_addr);
            mem_latency = 1 + next_rand() % 4;
        end
    endtask

    // one clock cycle of random stimulus
    // a branch never comes together with a pop
    task automatic step(input int unsigned pop_pct, input int unsigned branch_pct);
        @(posedge clk);
        #1;
        drive_memory();
        load_new_ip = 1'b0;
        rd_en       = 1'b0;
        if (branch_pct != 0 && next_rand() % 100 < branch_pct) begin
            load_new_ip = 1'b1;
            new_cs      = fetch_pkg::offset_t'(next_rand());
            new_ip      = fetch_pkg::offset_t'(next_rand());
        end else if (!empty && next_rand() % 100 < pop_pct) begin
            rd_en = 1'b1;
        end
    endtask

    task automatic branch_to(input fetch_pkg::offset_t cs, input fetch_pkg::offset_t ip);
        @(posedge clk);
        #1;
        drive_memory();
        rd_en       = 1'b0;
        load_new_ip = 1'b1;
        new_cs      = cs;
        new_ip      = ip;
    endtask

    // everything is sampled mid-cycle, where inputs and outputs have settled
    always @(negedge clk) begin
        if (reset) begin
            // the first assignment of the clock at time 0 also counts as a
            // falling edge, before the DUT has seen its reset
            if ($time > 0) begin
                check_value("mem_access", 32'(mem_access), 32'd0);
                check_value("empty", 32'(empty), 32'd1);
            end
            req_cycles = 0;
        end else begin
            if (mem_ack) begin
                // the request must drop in the ack cycle
                check_value("mem_access", 32'(mem_access), 32'd0);
                req_cycles = 0;
            end else if (mem_access) begin
                if (req_cycles == 0) begin
                    req_addr = mem_address;
                end else begin
                    check_value("mem_address", 32'(mem_address), 32'(req_addr));
                end
                if (first_req) begin
                    check_value("mem_address", 32'(mem_address),
                                32'(phys_of(`FETCH_RESET_CS, `FETCH_RESET_IP) >> 1));
                    first_req = 1'b0;
                end
                req_cycles++;
                if (req_cycles > 4) begin
                    report_failure("mem_access high for more than 4 cycles without an ack");
                end
            end else if (req_cycles != 0) begin
                report_failure("mem_access dropped before the memory answered");
                req_cycles = 0;
            end
            // the model follows the head byte through pops and branches
            if (load_new_ip) begin
                exp_cs = new_cs;
                exp_ip = new_ip;
                branches++;
            end else if (rd_en) begin
                check_value("rd_data", 32'(rd_data), 32'(byte_at(phys_of(exp_cs, exp_ip))));
                check_value("fetch_ip", 32'(fetch_ip), 32'(exp_ip));
                exp_ip = exp_ip + 16'd1;
                pops++;
            end
        end
    end

    initial begin
        int unsigned popped;
        int unsigned waited;
        reset       = 1'b1;
        new_cs      = '0;
        new_ip      = '0;
        load_new_ip = 1'b0;
        mem_ack     = 1'b0;
        mem_data    = '0;
        rd_en       = 1'b0;
        mem_latency = 1 + next_rand() % 4;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // plain sequential stream from the reset address
        repeat (SEQ_CYCLES) step(50, 0);

        // let the queue fill up, then drain it hard
        repeat (BP_ROUNDS) begin
            repeat (BP_HOLD) step(0, 0);
            repeat (BP_RUN) step(90, 0);
        end

        // branches at random points land on an access in flight now and then
        repeat (BRANCH_CYCLES) step(60, 5);

        // four bytes below the segment limit, so the offset has to wrap
        branch_to(fetch_pkg::offset_t'(next_rand()), 16'hfffc);
        popped = 0;
        waited = 0;
        while (popped < 8 && waited < WRAP_WAIT) begin
            step(100, 0);
            if (rd_en) begin
                popped++;
            end
            waited++;
        end
        step(0, 0);
        if (popped != 8) begin
            report_failure("queue did not deliver 8 bytes after the branch to offset fffc");
        end else begin
            check_value("fetch_ip", 32'(fetch_ip), 32'h0000_0004);
        end

        repeat (TAIL_CYCLES) step(0, 0);
        if (pops < 100) begin
            report_failure("too few bytes were popped for a meaningful run");
        end

        $display("fetch_tb: %0d checks, %0d errors, %0d bytes popped, %0d branches",
                 checks, errors, pops, branches);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // the limit is about 2.5 times the planned run
    initial begin
        #(PLANNED_CYCLES * 20);
        $display("watchdog: run did not finish within %0d ns, %0d errors so far",
                 PLANNED_CYCLES * 20, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: dv/tb_clock.sv
// Testbench clock
`timescale 1ns/100ps

module tb_clock #(
    parameter int unsigned HALF_PERIOD = 4
) (
    output logic clk
);

    // 8 ns period with the default half period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule
